// File: design/block_dispatch.sv
`timescale 1ns/100ps

`include "piso_consts.svh"

// round-robin steering of incoming blocks to the lanes
// the merger walks the lanes in the same order so blocks keep their order
module block_dispatch
    import piso_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       reset_i,

    // ready-then-valid input handshake from outside
    input  logic                       valid_i,
    output logic                       ready_o,

    // one ready bit per lane and one valid bit per lane
    input  logic [`PISO_NUM_LANES-1:0] lane_ready_i,
    output logic [`PISO_NUM_LANES-1:0] lane_valid_o
);

    // highest lane index where the pointer wraps back to lane 0
    localparam lane_idx_t LAST_LANE = lane_idx_t'(`PISO_NUM_LANES - 1);

    // lane that receives the next accepted block
    lane_idx_t lane_ptr_r;

    // a block moves into the pointed lane on this cycle
    logic      xfer;

    // ready comes straight from the pointed lane
    // the lane raises it in the same cycle as its last yumi so a reload has no bubble
    assign ready_o = lane_ready_i[lane_ptr_r];

    // the transfer happens only when the selected lane is ready and the source is valid
    assign xfer = valid_i & ready_o;

    // only the pointed lane may see valid
    // all other lanes stay quiet even though they see the same block data
    always_comb
    begin
        lane_valid_o             = '0;
        lane_valid_o[lane_ptr_r] = valid_i;
    end

    // the pointer advances on every accepted block and wraps after the last lane
    // it never moves without a transfer so no lane is skipped
    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            lane_ptr_r <= '0;
        end
        else if (xfer)
        begin
            if (lane_ptr_r == LAST_LANE)
            begin
                lane_ptr_r <= '0;
            end
            else
            begin
                lane_ptr_r <= lane_ptr_r + 1'b1;
            end
        end
    end

endmodule

// File: design/parallel_in_serial_out.sv
`timescale 1ns/100ps

`include "piso_consts.svh"

// one lane that takes a whole block and hands it out one word at a time
// the input side is ready-then-valid and the output side is valid-then-yumi
// words always leave from index 0 upward
module parallel_in_serial_out
    import piso_pkg::*;
(
    input  logic   clk_i,
    input  logic   reset_i,

    // parallel block input
    input  logic   valid_i,
    input  block_t data_i,
    output logic   ready_o,

    // serial word output
    output logic   valid_o,
    output word_t  data_o,
    input  logic   yumi_i
);

    // index of the final word of a block
    localparam word_idx_t LAST_WORD = word_idx_t'(`PISO_BLOCK_ELS - 1);

    // receive or transmit state of the lane
    lane_state_e state_r;
    lane_state_e state_n;

    // the stored block and the pointer to the word on the output
    block_t      block_r;
    word_idx_t   word_idx_r;

    // handshake events of this cycle
    logic        accept;
    logic        done_tx;

    // the last word of the block is taken by the consumer in this cycle
    assign done_tx = (state_r == LANE_TX) && (word_idx_r == LAST_WORD) && yumi_i;

    // an empty lane is always ready
    // a full lane is ready once its last word is being taken
    // this makes ready depend on yumi but it removes the bubble between blocks
    assign ready_o = (state_r == LANE_RX) || done_tx;

    // a new block loads at this edge
    assign accept = valid_i & ready_o;

    // the lane only has data to show while it is transmitting
    assign valid_o = (state_r == LANE_TX);

    // the counter picks the word on the output
    assign data_o = block_r[word_idx_r];

    // next state
    // a new block wins over the return to receive so back to back blocks stay in TX
    always_comb
    begin
        state_n = state_r;
        case (state_r)
            LANE_RX:
            begin
                if (accept)
                begin
                    state_n = LANE_TX;
                end
            end
            LANE_TX:
            begin
                if (accept)
                begin
                    state_n = LANE_TX;
                end
                else if (done_tx)
                begin
                    state_n = LANE_RX;
                end
            end
            default:
            begin
                state_n = LANE_RX;
            end
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            state_r <= LANE_RX;
        end
        else
        begin
            state_r <= state_n;
        end
    end

    // block storage only changes on accept
    always_ff @(posedge clk_i)
    begin
        if (accept)
        begin
            block_r <= data_i;
        end
    end

    // word counter clears for every new block
    // it steps on each yumi and stays on the last word when the block finishes
    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            word_idx_r <= '0;
        end
        else if (accept)
        begin
            word_idx_r <= '0;
        end
        else if ((state_r == LANE_TX) && yumi_i && !done_tx)
        begin
            word_idx_r <= word_idx_r + 1'b1;
        end
    end

endmodule

// File: design/piso_array_top.sv
`timescale 1ns/100ps

`include "piso_consts.svh"

// multi-lane block serializer
// blocks enter on a ready-then-valid port and leave as words on a valid-then-yumi port
// the dispatcher and the merger rotate over the lanes in the same order
module piso_array_top
    import piso_pkg::*;
(
    input  logic   clk_i,
    input  logic   reset_i,

    // parallel block input
    input  logic   valid_i,
    input  block_t data_i,
    output logic   ready_o,

    // serial word output
    output logic   valid_o,
    output word_t  data_o,
    input  logic   yumi_i
);

    // dispatcher side of the lanes
    logic  [`PISO_NUM_LANES-1:0] lane_valid_in;
    logic  [`PISO_NUM_LANES-1:0] lane_ready;

    // merger side of the lanes
    logic  [`PISO_NUM_LANES-1:0] lane_valid_out;
    word_t [`PISO_NUM_LANES-1:0] lane_data_out;
    logic  [`PISO_NUM_LANES-1:0] lane_yumi;

    // picks the lane for each new block
    block_dispatch u_dispatch (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .valid_i      (valid_i),
        .ready_o      (ready_o),
        .lane_ready_i (lane_ready),
        .lane_valid_o (lane_valid_in)
    );

    // every lane sees the same block data
    // only the lane with valid set takes it
    for (genvar lane = 0; lane < `PISO_NUM_LANES; lane++)
    begin : g_lane
        parallel_in_serial_out u_lane (
            .clk_i   (clk_i),
            .reset_i (reset_i),
            .valid_i (lane_valid_in[lane]),
            .data_i  (data_i),
            .ready_o (lane_ready[lane]),
            .valid_o (lane_valid_out[lane]),
            .data_o  (lane_data_out[lane]),
            .yumi_i  (lane_yumi[lane])
        );
    end

    // collects the words back into one stream in block order
    word_merge u_merge (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .lane_valid_i (lane_valid_out),
        .lane_data_i  (lane_data_out),
        .lane_yumi_o  (lane_yumi),
        .valid_o      (valid_o),
        .data_o       (data_o),
        .yumi_i       (yumi_i)
    );

endmodule

// File: design/piso_pkg.sv
`include "piso_consts.svh"

package piso_pkg;

    // one word as it leaves the serial output
    typedef logic [`PISO_WORD_W-1:0] word_t;

    // a whole block where index 0 is the first word sent
    typedef word_t [`PISO_BLOCK_ELS-1:0] block_t;

    // selects one of the lanes in the dispatcher and the merger
    typedef logic [$clog2(`PISO_NUM_LANES)-1:0] lane_idx_t;

    // position of a word inside its block
    typedef logic [$clog2(`PISO_BLOCK_ELS)-1:0] word_idx_t;

    // a lane either waits for a block or sends one out word by word
    typedef enum logic [0:0] {LANE_RX, LANE_TX} lane_state_e;

endpackage

// File: design/word_merge.sv
`timescale 1ns/100ps

`include "piso_consts.svh"

// drains the lanes one whole block at a time into a single word stream
// the lane order matches the dispatcher so blocks come out in arrival order
module word_merge
    import piso_pkg::*;
(
    input  logic                                clk_i,
    input  logic                                reset_i,

    // word outputs of all lanes
    input  logic  [`PISO_NUM_LANES-1:0]         lane_valid_i,
    input  word_t [`PISO_NUM_LANES-1:0]         lane_data_i,
    output logic  [`PISO_NUM_LANES-1:0]         lane_yumi_o,

    // merged valid-then-yumi output
    output logic                                valid_o,
    output word_t                               data_o,
    input  logic                                yumi_i
);

    // wrap points for the lane pointer and the word count
    localparam lane_idx_t LAST_LANE = lane_idx_t'(`PISO_NUM_LANES - 1);
    localparam word_idx_t LAST_WORD = word_idx_t'(`PISO_BLOCK_ELS - 1);

    // lane being drained and the number of its words already taken
    lane_idx_t cur_lane_r;
    word_idx_t word_cnt_r;

    // the consumer takes the last word of the current block
    logic      block_done;

    // outputs come straight from the current lane with no register in between
    // so a word shows in the same cycle the lane presents it
    assign valid_o = lane_valid_i[cur_lane_r];
    assign data_o  = lane_data_i[cur_lane_r];

    assign block_done = yumi_i && (word_cnt_r == LAST_WORD);

    // yumi goes to the current lane only
    // the other lanes keep their words until their turn comes
    always_comb
    begin
        lane_yumi_o             = '0;
        lane_yumi_o[cur_lane_r] = yumi_i;
    end

    // the word count tracks progress through the block
    // yumi is only legal while valid is high so every yumi is a real word
    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            word_cnt_r <= '0;
        end
        else if (block_done)
        begin
            word_cnt_r <= '0;
        end
        else if (yumi_i)
        begin
            word_cnt_r <= word_cnt_r + 1'b1;
        end
    end

    // after the last word of a block the pointer steps to the next lane
    // this lane holds the next block in order since the dispatcher filled it next
    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            cur_lane_r <= '0;
        end
        else if (block_done)
        begin
            if (cur_lane_r == LAST_LANE)
            begin
                cur_lane_r <= '0;
            end
            else
            begin
                cur_lane_r <= cur_lane_r + 1'b1;
            end
        end
    end

endmodule

// File: dv/piso_array_tb.sv
`timescale 1ns/100ps

`include "piso_consts.svh"

// random block traffic into the serializer with a queue model of the word stream
module piso_array_tb
    import piso_pkg::*;
();

    localparam int          NUM_BLOCKS     = 400;
    localparam int          TIMEOUT_CYCLES = NUM_BLOCKS * `PISO_BLOCK_ELS * 10;
    localparam int          PHASE_LEN      = 50;
    localparam int unsigned RAND_SEED      = 32'h2be8_698a;

    // traffic modes that change every phase
    localparam int MODE_QUIET = 0;
    localparam int MODE_MIXED = 1;
    localparam int MODE_FULL  = 2;

    logic   clk_i;
    logic   reset_i;
    logic   valid_i;
    block_t data_i;
    logic   ready_o;
    logic   valid_o;
    word_t  data_o;
    logic   yumi_i;

    // expected words in the order they must leave
    word_t       model_q[$];
    block_t      cur_block;
    logic        have_block;
    int          blocks_sent;
    int          words_taken;
    int          value_errs;
    int          other_errs;
    int          cycle_cnt;
    int          mode;
    int          phase_cnt;
    logic        stream_on;
    logic        hold_pending;
    word_t       hold_data;

    piso_array_top dut (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .valid_i (valid_i),
        .data_i  (data_i),
        .ready_o (ready_o),
        .valid_o (valid_o),
        .data_o  (data_o),
        .yumi_i  (yumi_i)
    );

    initial
    begin
        clk_i = 1'b0;
        forever
        begin
            #2 clk_i = ~clk_i;
        end
    end

    // cycle counter for the run limit
    initial
    begin
        cycle_cnt = 0;
    end

    always @(posedge clk_i)
    begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial
    begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("test failed");
        $finish;
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act)
        begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act)
        begin
            $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act)
        begin
            $display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
            value_errs++;
        end
    endtask

    // true with the given chance in percent
    function automatic logic roll_percent(input int pct);
        return ($urandom % 100) < pct;
    endfunction

    // every word of a new block gets its own random value
    function automatic block_t random_block();
        block_t blk;
        for (int w = 0; w < `PISO_BLOCK_ELS; w++)
        begin
            blk[w] = word_t'($urandom);
        end
        return blk;
    endfunction

    initial
    begin
        void'($urandom(RAND_SEED));
        reset_i      = 1'b1;
        valid_i      = 1'b0;
        data_i       = '0;
        yumi_i       = 1'b0;
        have_block   = 1'b0;
        blocks_sent  = 0;
        words_taken  = 0;
        value_errs   = 0;
        other_errs   = 0;
        phase_cnt    = 0;
        // the first phase runs at full speed so the no-bubble stream is always seen
        mode         = MODE_FULL;
        stream_on    = 1'b0;
        hold_pending = 1'b0;
        hold_data    = '0;

        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        #1;
        check_bit("reset valid_o", 1'b0, valid_o);
        check_bit("reset ready_o", 1'b1, ready_o);

        // the loop goes on until all blocks are in and the DUT offers no more words
        @(negedge clk_i);
        while (blocks_sent < NUM_BLOCKS || valid_o)
        begin
            phase_cnt++;
            if (phase_cnt == PHASE_LEN)
            begin
                phase_cnt = 0;
                mode      = $urandom % 3;
                stream_on = 1'b0;
            end

            // a stalled word must still be there with the same value
            if (hold_pending)
            begin
                check_bit("hold valid_o", 1'b1, valid_o);
                check_word("hold data_o", hold_data, data_o);
            end

            // once the stream is running at full speed it has no gaps
            if (blocks_sent >= NUM_BLOCKS)
            begin
                stream_on = 1'b0;
            end
            if (stream_on)
            begin
                check_bit("full speed valid_o", 1'b1, valid_o);
            end
            else if (mode == MODE_FULL && valid_o && blocks_sent < NUM_BLOCKS)
            begin
                stream_on = 1'b1;
            end

            // data only moves on after the previous block was taken
            if (!have_block && blocks_sent < NUM_BLOCKS)
            begin
                cur_block  = random_block();
                have_block = 1'b1;
            end
            data_i = cur_block;
            case (mode)
                MODE_QUIET:
                begin
                    valid_i = have_block && roll_percent(40);
                    yumi_i  = valid_o && roll_percent(25);
                end
                MODE_MIXED:
                begin
                    valid_i = have_block && roll_percent(60);
                    yumi_i  = valid_o && roll_percent(60);
                end
                default:
                begin
                    valid_i = have_block;
                    yumi_i  = valid_o;
                end
            endcase

            // sample both handshakes in the middle of the low phase
            #1;
            if (valid_i && ready_o)
            begin
                for (int w = 0; w < `PISO_BLOCK_ELS; w++)
                begin
                    model_q.push_back(cur_block[w]);
                end
                blocks_sent++;
                have_block = 1'b0;
            end
            if (valid_o && yumi_i)
            begin
                if (model_q.size() == 0)
                begin
                    $display("error: the DUT offered a word that was never sent in");
                    other_errs++;
                end
                else
                begin
                    check_word("output word order", model_q.pop_front(), data_o);
                end
                words_taken++;
            end
            hold_pending = valid_o && !yumi_i;
            hold_data    = data_o;
            @(negedge clk_i);
        end

        // the DUT has gone idle so the handshakes stop here
        valid_i = 1'b0;
        yumi_i  = 1'b0;
        repeat (4) @(negedge clk_i);
        check_bit("drained valid_o", 1'b0, valid_o);
        check_bit("drained ready_o", 1'b1, ready_o);
        // every word that went in must have come out before the DUT went idle
        check_count("words taken", blocks_sent * `PISO_BLOCK_ELS, words_taken);
        check_count("model queue size", 0, model_q.size());

        $display("summary: blocks %0d words %0d value errors %0d other errors %0d",
                 blocks_sent, words_taken, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: include/piso_consts.svh
`ifndef PISO_CONSTS_SVH
`define PISO_CONSTS_SVH

// width of one serial word on the output side
`define PISO_WORD_W 16

// number of words packed into one parallel block
// this must stay above one since the lane has no single word path
`define PISO_BLOCK_ELS 4

// number of identical lanes that the dispatcher rotates over
// more lanes give more buffering before the input sees back-pressure
`define PISO_NUM_LANES 3

`endif

// File: project.f
+incdir+include
design/piso_pkg.sv
design/block_dispatch.sv
design/parallel_in_serial_out.sv
design/word_merge.sv
design/piso_array_top.sv
dv/piso_array_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the serializer testbench with Verilator and runs it into sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f project.f --top-module piso_array_tb \
    -o piso_sim \
    && ./obj_dir/piso_sim > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }
cat sim.log
# the run is a failure whenever the log holds the fail message
grep -q "test failed" sim.log \
    && { echo "simulation reported a failure"; exit 1; } \
    || { echo "simulation finished without failure"; exit 0; }
